/* hw/avm_pkg.sv */
package avm_pkg;

    // Avalon side of the serial port
    localparam int addr_width = 5;

    // register map, byte addresses
    localparam logic [addr_width-1:0] rx_base     = 5'd0;  // receive data
    localparam logic [addr_width-1:0] tx_base     = 5'd4;  // transmit data
    localparam logic [addr_width-1:0] status_base = 5'd8;

    // status register bits
    localparam int tx_ok_bit = 6;  // transmitter can take a byte
    localparam int rx_ok_bit = 7;  // received byte waiting

    // top level sequence of the wrapper
    typedef enum logic [2:0] {
        get_key_n,
        get_key_d,
        get_data,
        wait_calc,
        send_data
    } wrap_state_e;

    // phase within one byte
    typedef enum logic {
        io_poll,  // status read in flight
        io_xfer   // data read or write in flight
    } io_state_e;

endpackage

/* hw/rsa_pkg.sv */
package rsa_pkg;

    localparam int key_bits  = 256;
    localparam int key_bytes = key_bits / 8;  // bytes per operand read
    localparam int out_bytes = key_bytes - 1;  // top byte of the result is not sent

    // exponentiation sequence
    typedef enum logic [1:0] {
        idle,
        prescale,
        exp_loop,
        done
    } core_state_e;

    // montgomery multiplier
    typedef enum logic {
        mont_idle,
        mont_run
    } mont_state_e;

endpackage

/* hw/rsa_mont_mult.sv */
`timescale 1ns/1ns

module rsa_mont_mult (
    input  logic                         avm_clk,
    input  logic                         avm_rst,
    input  logic                         start,
    input  logic [rsa_pkg::key_bits-1:0] op_a,
    input  logic [rsa_pkg::key_bits-1:0] op_b,
    input  logic [rsa_pkg::key_bits-1:0] mod_n,
    output logic [rsa_pkg::key_bits-1:0] product,
    output logic                         done
);

    rsa_pkg::mont_state_e state;
    logic [$clog2(rsa_pkg::key_bits):0] cnt;  // 0..key_bits, last value is the subtract step

    logic [rsa_pkg::key_bits-1:0] a_r;  // shifts right, bit 0 is the current bit
    logic [rsa_pkg::key_bits-1:0] b_r;
    logic [rsa_pkg::key_bits-1:0] n_r;
    logic [rsa_pkg::key_bits+1:0] acc;  // stays below 2n
    logic [rsa_pkg::key_bits+1:0] sum_b;
    logic [rsa_pkg::key_bits+1:0] sum_n;
    logic [rsa_pkg::key_bits+1:0] diff;

    always_comb begin
        sum_b = acc + (a_r[0] ? {2'b00, b_r} : '0);
        sum_n = sum_b[0] ? sum_b + {2'b00, n_r} : sum_b;  // make it even
        diff  = acc - {2'b00, n_r};
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state <= rsa_pkg::mont_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                rsa_pkg::mont_idle: begin
                    if (start) begin
                        state <= rsa_pkg::mont_run;
                        cnt   <= '0;
                    end
                end
                rsa_pkg::mont_run: begin
                    if (cnt == rsa_pkg::key_bits) begin
                        state <= rsa_pkg::mont_idle;
                        done  <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rsa_pkg::mont_idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (state == rsa_pkg::mont_idle) begin
            if (start) begin
                a_r <= op_a;
                b_r <= op_b;
                n_r <= mod_n;
                acc <= '0;
            end
        end else if (cnt == rsa_pkg::key_bits) begin
            // final conditional subtraction
            product <= (acc >= {2'b00, n_r}) ? diff[rsa_pkg::key_bits-1:0]
                                             : acc[rsa_pkg::key_bits-1:0];
        end else begin
            acc <= sum_n >> 1;
            a_r <= a_r >> 1;
        end
    end

    // the caller waits for done before the next start
    a_start_idle: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> state == rsa_pkg::mont_idle);

endmodule

/* hw/rsa_core.sv */
`timescale 1ns/1ns

module rsa_core (
    input  logic                         avm_clk,
    input  logic                         avm_rst,
    input  logic                         start,
    input  logic [rsa_pkg::key_bits-1:0] cipher,
    input  logic [rsa_pkg::key_bits-1:0] key_d,
    input  logic [rsa_pkg::key_bits-1:0] key_n,
    output logic [rsa_pkg::key_bits-1:0] result,
    output logic                         finished
);

    rsa_pkg::core_state_e state;
    logic [$clog2(rsa_pkg::key_bits)-1:0] step;  // wraps after the last step
    logic                                 last_step;
    logic                                 mult_start;

    logic [rsa_pkg::key_bits-1:0] n_r;
    logic [rsa_pkg::key_bits-1:0] d_r;    // shifts right, bit 0 is the current exponent bit
    logic [rsa_pkg::key_bits-1:0] base;   // cipher^(2^i) * 2^256 mod n
    logic [rsa_pkg::key_bits-1:0] acc_r;  // plain form, factors cancel
    logic [rsa_pkg::key_bits:0]   dbl;
    logic [rsa_pkg::key_bits:0]   dbl_red;

    logic [rsa_pkg::key_bits-1:0] sq_product;
    logic [rsa_pkg::key_bits-1:0] acc_product;
    logic                         sq_done;
    logic                         acc_done;

    assign dbl       = {base, 1'b0};
    assign dbl_red   = dbl - {1'b0, n_r};
    assign last_step = step == rsa_pkg::key_bits - 1;
    assign result    = acc_r;

    rsa_mont_mult i_mont_sq (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mult_start),
        .op_a    (base),
        .op_b    (base),
        .mod_n   (n_r),
        .product (sq_product),
        .done    (sq_done)
    );

    // only runs for set exponent bits
    rsa_mont_mult i_mont_acc (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mult_start & d_r[0]),
        .op_a    (acc_r),
        .op_b    (base),
        .mod_n   (n_r),
        .product (acc_product),
        .done    (acc_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= rsa_pkg::idle;
            step       <= '0;
            mult_start <= 1'b0;
            finished   <= 1'b0;
        end else begin
            mult_start <= 1'b0;
            finished   <= 1'b0;
            case (state)
                rsa_pkg::idle: begin
                    if (start) begin
                        state <= rsa_pkg::prescale;
                        step  <= '0;
                    end
                end
                rsa_pkg::prescale: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        state      <= rsa_pkg::exp_loop;
                        mult_start <= 1'b1;  // first exponent bit
                    end
                end
                rsa_pkg::exp_loop: begin
                    if (sq_done) begin
                        step <= step + 1'b1;
                        if (last_step)
                            state <= rsa_pkg::done;
                        else
                            mult_start <= 1'b1;
                    end
                end
                rsa_pkg::done: begin
                    finished <= 1'b1;
                    state    <= rsa_pkg::idle;
                end
                default: state <= rsa_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state)
            rsa_pkg::idle: begin
                if (start) begin
                    n_r   <= key_n;
                    d_r   <= key_d;
                    base  <= cipher;
                    acc_r <= {{(rsa_pkg::key_bits-1){1'b0}}, 1'b1};
                end
            end
            rsa_pkg::prescale: begin
                // base <= 2*base mod n
                base <= (dbl >= {1'b0, n_r}) ? dbl_red[rsa_pkg::key_bits-1:0]
                                             : dbl[rsa_pkg::key_bits-1:0];
            end
            rsa_pkg::exp_loop: begin
                if (sq_done) begin
                    base <= sq_product;
                    d_r  <= d_r >> 1;
                end
                if (acc_done)
                    acc_r <= acc_product;
            end
            default: ;
        endcase
    end

    a_finished_pulse: assert property (@(posedge avm_clk) disable iff (avm_rst)
        finished |=> !finished);

endmodule

/* hw/rsa_wrapper.sv */
`timescale 1ns/1ns

module rsa_wrapper (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    output logic [avm_pkg::addr_width-1:0] avm_address,
    output logic                           avm_read,
    input  logic [31:0]                    avm_readdata,
    output logic                           avm_write,
    output logic [31:0]                    avm_writedata,
    input  logic                           avm_waitrequest,
    output logic                           start,
    output logic [rsa_pkg::key_bits-1:0]   cipher,
    output logic [rsa_pkg::key_bits-1:0]   key_d,
    output logic [rsa_pkg::key_bits-1:0]   key_n,
    input  logic [rsa_pkg::key_bits-1:0]   result,
    input  logic                           finished
);

    avm_pkg::wrap_state_e state;
    avm_pkg::io_state_e   io;
    logic [$clog2(rsa_pkg::key_bytes)-1:0] byte_cnt;
    logic [rsa_pkg::key_bits-1:0]          res_r;  // result, shifted left per sent byte

    logic bus_done;
    logic poll_done;
    logic data_done;
    logic want_tx;
    logic ready;
    logic last_byte;
    logic issue_xfer;

    assign bus_done   = (avm_read || avm_write) && !avm_waitrequest;
    assign poll_done  = bus_done && io == avm_pkg::io_poll;
    assign data_done  = bus_done && io == avm_pkg::io_xfer;
    assign want_tx    = state == avm_pkg::send_data;
    assign ready      = want_tx ? avm_readdata[avm_pkg::tx_ok_bit]
                                : avm_readdata[avm_pkg::rx_ok_bit];
    assign last_byte  = byte_cnt == (want_tx ? rsa_pkg::out_bytes - 1 : rsa_pkg::key_bytes - 1);
    assign issue_xfer = poll_done && ready && state != avm_pkg::wait_calc;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state       <= avm_pkg::get_key_n;
            io          <= avm_pkg::io_poll;
            byte_cnt    <= '0;
            avm_address <= avm_pkg::status_base;  // polling right out of reset
            avm_read    <= 1'b1;
            avm_write   <= 1'b0;
            start       <= 1'b0;
        end else begin
            start <= 1'b0;
            if (issue_xfer) begin
                io          <= avm_pkg::io_xfer;
                avm_address <= want_tx ? avm_pkg::tx_base : avm_pkg::rx_base;
                avm_read    <= !want_tx;
                avm_write   <= want_tx;
            end else if (data_done) begin
                io          <= avm_pkg::io_poll;  // back to status
                avm_address <= avm_pkg::status_base;
                avm_read    <= 1'b1;
                avm_write   <= 1'b0;
                byte_cnt    <= last_byte ? '0 : byte_cnt + 1'b1;
                if (last_byte) begin
                    case (state)
                        avm_pkg::get_key_n: state <= avm_pkg::get_key_d;
                        avm_pkg::get_key_d: state <= avm_pkg::get_data;
                        avm_pkg::get_data: begin
                            state <= avm_pkg::wait_calc;
                            start <= 1'b1;
                        end
                        avm_pkg::send_data: state <= avm_pkg::get_data;  // same key
                        default: ;
                    endcase
                end
            end
            if (state == avm_pkg::wait_calc && finished)
                state <= avm_pkg::send_data;
        end
    end

    always_ff @(posedge avm_clk) begin
        if (data_done && avm_read) begin
            // msb first
            case (state)
                avm_pkg::get_key_n: key_n  <= {key_n[rsa_pkg::key_bits-9:0], avm_readdata[7:0]};
                avm_pkg::get_key_d: key_d  <= {key_d[rsa_pkg::key_bits-9:0], avm_readdata[7:0]};
                avm_pkg::get_data:  cipher <= {cipher[rsa_pkg::key_bits-9:0], avm_readdata[7:0]};
                default: ;
            endcase
        end
        if (issue_xfer && want_tx)
            avm_writedata <= {24'd0, res_r[rsa_pkg::out_bytes*8-1 -: 8]};
        if (state == avm_pkg::wait_calc && finished)
            res_r <= result;
        else if (data_done && avm_write)
            res_r <= res_r << 8;
    end

    a_rw_exclusive: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write));

    // a stalled access is held until it completes
    a_hold_on_wait: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write));

    a_start_after_data: assert property (@(posedge avm_clk) disable iff (avm_rst)
        start |-> $past(state == avm_pkg::get_data && data_done
                        && byte_cnt == rsa_pkg::key_bytes - 1));

endmodule

/* hw/rsa_top.sv */
`timescale 1ns/1ns

module rsa_top (
    input  logic                           avm_clk,
    input  logic                           avm_rst,
    output logic [avm_pkg::addr_width-1:0] avm_address,
    output logic                           avm_read,
    input  logic [31:0]                    avm_readdata,
    output logic                           avm_write,
    output logic [31:0]                    avm_writedata,
    input  logic                           avm_waitrequest
);

    logic                         start;
    logic                         finished;
    logic [rsa_pkg::key_bits-1:0] cipher;
    logic [rsa_pkg::key_bits-1:0] key_d;
    logic [rsa_pkg::key_bits-1:0] key_n;
    logic [rsa_pkg::key_bits-1:0] result;

    rsa_wrapper i_wrapper (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest),
        .start           (start),
        .cipher          (cipher),
        .key_d           (key_d),
        .key_n           (key_n),
        .result          (result),
        .finished        (finished)
    );

    rsa_core i_core (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (start),
        .cipher   (cipher),
        .key_d    (key_d),
        .key_n    (key_n),
        .result   (result),
        .finished (finished)
    );

endmodule

/* tests/rsa_tb.sv */
`timescale 1ns/1ns

module rsa_tb;

    localparam int seed         = 32'he8c9;
    localparam int num_random   = 3;       // random ciphertexts under the first key
    localparam int result_wait  = 400000;  // cycles per ciphertext, key bytes included
    localparam int quiet_cycles = 64;      // window for extra bytes after a result
    localparam logic [255:0] small_n = 256'd3233;  // 61 * 53
    localparam logic [255:0] small_d = 256'd2753;

    logic                           avm_clk;
    logic                           avm_rst;
    logic [avm_pkg::addr_width-1:0] avm_address;
    logic                           avm_read;
    logic [31:0]                    avm_readdata;
    logic                           avm_write;
    logic [31:0]                    avm_writedata;
    logic                           avm_waitrequest;

    logic [7:0]   rx_q[$];   // bytes waiting in the receiver
    logic [7:0]   cap_q[$];  // bytes taken by the transmitter
    logic [247:0] exp_q[$];
    string        name_q[$];
    logic [31:0]  last_status;  // last completed status read
    int           err_cnt;
    int           test_cnt;
    int           done_cnt;
    int           rnd;

    rsa_top i_dut (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_readdata    (avm_readdata),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    always #50 avm_clk = ~avm_clk;

    // square and multiply, lsb first
    function automatic logic [247:0] ref_modexp(input logic [255:0] c, input logic [255:0] d,
                                                input logic [255:0] n);
        logic [511:0] r;
        logic [511:0] b;
        r = 512'd1;
        b = c % n;
        for (int i = 0; i < 256; i++) begin
            if (d[i])
                r = (r * b) % n;
            b = (b * b) % n;
        end
        return r[247:0];
    endfunction

    function automatic logic [255:0] rand_256();
        logic [255:0] v;
        v = '0;
        for (int i = 0; i < 8; i++)
            v = {v[223:0], $urandom};
        return v;
    endfunction

    function automatic logic [31:0] read_value(input logic [avm_pkg::addr_width-1:0] addr);
        logic [31:0] v;
        v = '0;
        if (addr == avm_pkg::status_base) begin
            v[avm_pkg::rx_ok_bit] = rx_q.size() > 0 && $urandom % 4 != 0;  // rx_ok held back now and then
            v[avm_pkg::tx_ok_bit] = $urandom % 3 != 0;
        end else if (addr == avm_pkg::rx_base && rx_q.size() > 0) begin
            v[7:0] = rx_q[0];
        end
        return v;
    endfunction

    task automatic complete_access();
        if (avm_read && avm_address == avm_pkg::status_base) begin
            last_status = avm_readdata;
        end else if (avm_read && avm_address == avm_pkg::rx_base) begin
            if (!last_status[avm_pkg::rx_ok_bit] || rx_q.size() == 0) begin
                $display("ERROR data read while no received byte was waiting");
                err_cnt++;
            end else begin
                rx_q.delete(0);
            end
            last_status = '0;
        end else if (avm_write && avm_address == avm_pkg::tx_base) begin
            if (!last_status[avm_pkg::tx_ok_bit]) begin
                $display("ERROR byte written while the transmitter was not ready");
                err_cnt++;
            end
            cap_q.push_back(avm_writedata[7:0]);
            last_status = '0;
        end else begin
            $display("ERROR access to unexpected address %h", avm_address);
            err_cnt++;
        end
    endtask

    // serial port model, every access waits at least one cycle
    always @(posedge avm_clk) begin
        if (avm_rst) begin
            avm_waitrequest <= 1'b1;
            avm_readdata    <= '0;
            last_status = '0;
        end else if ((avm_read || avm_write) && avm_waitrequest) begin
            if ($urandom % 2 == 0) begin
                avm_waitrequest <= 1'b0;
                avm_readdata    <= read_value(avm_address);
            end
        end else if (avm_read || avm_write) begin
            complete_access();  // completed at this edge
            avm_waitrequest <= 1'b1;
        end
    end

    task automatic check_value(input string name, input logic [255:0] expected,
                               input logic [255:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("TIMEOUT %s", why);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic push_operand(input logic [255:0] v);
        for (int i = 31; i >= 0; i--)
            rx_q.push_back(v[i*8 +: 8]);  // msb first
    endtask

    task automatic load_key(input logic [255:0] n, input logic [255:0] d);
        @(posedge avm_clk);
        avm_rst <= 1'b1;
        repeat (7) @(posedge avm_clk);
        rx_q.delete();
        cap_q.delete();
        push_operand(n);
        push_operand(d);
        avm_rst <= 1'b0;
    endtask

    task automatic run_test(input string name, input logic [255:0] n, input logic [255:0] d,
                            input logic [255:0] c);
        int t;
        t = 0;
        exp_q.push_back(ref_modexp(c, d, n));
        name_q.push_back(name);
        test_cnt++;
        @(negedge avm_clk);
        push_operand(c);
        while (done_cnt < test_cnt && t < result_wait) begin
            @(posedge avm_clk);
            t++;
        end
        if (done_cnt < test_cnt) begin
            abort_run({"no result for ", name});
        end else begin
            // a repeated byte would show up shortly after the result
            repeat (quiet_cycles) @(posedge avm_clk);
            check_value({name, " extra bytes"}, 0, cap_q.size());
        end
    endtask

    // comparing process, one result per 31 captured bytes
    always @(posedge avm_clk) begin : compare
        logic [247:0] actual;
        logic [247:0] expected;
        string        name;
        if (exp_q.size() > 0 && cap_q.size() >= rsa_pkg::out_bytes) begin
            actual = '0;
            for (int i = 0; i < rsa_pkg::out_bytes; i++)
                actual = {actual[239:0], cap_q.pop_front()};
            expected = exp_q.pop_front();
            name     = name_q.pop_front();
            check_value(name, expected, actual);
            $display("test %s: %s", name, actual === expected ? "ok" : "mismatch");
            done_cnt++;
        end
    end

    initial begin
        logic [255:0] n_big;
        logic [255:0] d_big;
        avm_clk         = 1'b0;
        avm_rst         = 1'b1;
        avm_readdata    = '0;
        avm_waitrequest = 1'b1;
        last_status     = '0;
        err_cnt         = 0;
        test_cnt        = 0;
        done_cnt        = 0;
        rnd             = $urandom(seed);

        load_key(small_n, small_d);
        run_test("known", small_n, small_d, 256'd2790);
        for (int i = 0; i < num_random; i++)
            run_test($sformatf("random_%0d", i), small_n, small_d, rand_256() % small_n);
        run_test("cipher_zero", small_n, small_d, 256'd0);
        run_test("cipher_one", small_n, small_d, 256'd1);

        // wide odd modulus just below 2^248
        n_big          = rand_256();
        n_big[255:248] = 8'd0;
        n_big[247]     = 1'b1;
        n_big[0]       = 1'b1;
        load_key(n_big, 256'd1);
        run_test("exponent_one", n_big, 256'd1, rand_256() % n_big);
        d_big = rand_256();
        load_key(n_big, d_big);
        run_test("wide_key", n_big, d_big, rand_256() % n_big);

        $display("tests %0d, results %0d, errors %0d", test_cnt, done_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* tb.f */
hw/avm_pkg.sv
hw/rsa_pkg.sv
hw/rsa_mont_mult.sv
hw/rsa_core.sv
hw/rsa_wrapper.sv
hw/rsa_top.sv
tests/rsa_tb.sv

/* Bender.yml */
package:
  name: rsa_decrypt

sources:
  # packages first, then the design bottom up
  - files:
      - hw/avm_pkg.sv
      - hw/rsa_pkg.sv
      - hw/rsa_mont_mult.sv
      - hw/rsa_core.sv
      - hw/rsa_wrapper.sv
      - hw/rsa_top.sv

  - target: test
    files:
      - tests/rsa_tb.sv

# simulation top: rsa_tb
# design top: rsa_top
